// ==== mvm_part_params.svh ====
// Shared widths and register map of the mvm_part partition
// Stream word layout, AXI4-Lite sizes and the CSR offsets
`ifndef MVM_PART_PARAMS_SVH
`define MVM_PART_PARAMS_SVH

// ----------------------------------------------------------------------
// Stream words
// ----------------------------------------------------------------------
`define MVM_PWORD_W 32
`define MVM_LANES 4
`define MVM_ELEM_W 8

// ----------------------------------------------------------------------
// AXI4-Lite config port
// ----------------------------------------------------------------------
`define MVM_ADDR_W 8
`define MVM_DATA_W 32

// Register offsets
`define MVM_REG_CTRL 8'h00
`define MVM_REG_SHIFT 8'h04
`define MVM_REG_TARGET 8'h08
`define MVM_REG_COUNT 8'h0C
`define MVM_REG_IRQ 8'h10

`endif

// ==== mvm_part_pkg.sv ====
// Types shared across the mvm_part partition
// Stream payloads, accumulator, CSR fields and AXI4-Lite FSM states
`include "mvm_part_params.svh"

package mvm_part_pkg;

  // Stream payloads
  typedef logic [`MVM_PWORD_W-1:0] pword_t;
  typedef logic signed [`MVM_ELEM_W-1:0] elem_t;

  // Dot product accumulator, also the result word
  typedef logic signed [`MVM_PWORD_W-1:0] acc_t;

  // CSR fields
  typedef logic [4:0] shift_t;
  typedef logic [15:0] cnt_t;

  // AXI response codes
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } axil_wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } axil_rd_state_e;

endpackage

// ==== mvm_spill_reg.sv ====
// Two-entry valid/ready spill register
// Both the forward path and the ready path leave from flops
`timescale 1ns/100ps

module mvm_spill_reg #(
  parameter int DataWidth = 33
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  output logic                 o_ready,
  input  logic [DataWidth-1:0] i_data,
  output logic                 o_valid,
  input  logic                 i_ready,
  output logic [DataWidth-1:0] o_data
);

  logic                 main_valid_q;
  logic                 spill_valid_q;
  logic [DataWidth-1:0] main_data_q;
  logic [DataWidth-1:0] spill_data_q;
  logic                 in_fire;
  logic                 out_fire;
  logic                 main_load;
  logic                 spill_load;

  assign o_valid = main_valid_q;
  assign o_data  = main_data_q;
  // Ready drops only once both entries are taken
  assign o_ready = !spill_valid_q;

  assign in_fire  = i_valid && o_ready;
  assign out_fire = main_valid_q && i_ready;

  // New beat lands in main when main is empty or draining, else it spills
  assign main_load  = in_fire && (!main_valid_q || out_fire);
  assign spill_load = in_fire && main_valid_q && !i_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
    end else if (spill_valid_q) begin
      // Main stays full, refilled from the spill entry
      if (out_fire) spill_valid_q <= 1'b0;
    end else begin
      if (spill_load) spill_valid_q <= 1'b1;
      if (main_load) main_valid_q <= 1'b1;
      else if (out_fire) main_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (spill_valid_q && out_fire) main_data_q <= spill_data_q;
    else if (main_load) main_data_q <= i_data;
    if (spill_load) spill_data_q <= i_data;
  end

  a_hold_stable: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data))
  );

endmodule

// ==== mvm_cfg_ctrl.sv ====
// Config and interrupt block of the partition
// AXI4-Lite CSRs, result counter and sticky target-reached interrupt
`timescale 1ns/100ps
`include "mvm_part_params.svh"

module mvm_cfg_ctrl
  import mvm_part_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  // AXI4-Lite slave
  input  logic                      i_cfg_awvalid,
  output logic                      o_cfg_awready,
  input  logic [`MVM_ADDR_W-1:0]    i_cfg_awaddr,
  input  logic                      i_cfg_wvalid,
  output logic                      o_cfg_wready,
  input  logic [`MVM_DATA_W-1:0]    i_cfg_wdata,
  input  logic [`MVM_DATA_W/8-1:0]  i_cfg_wstrb,
  output logic                      o_cfg_bvalid,
  input  logic                      i_cfg_bready,
  output resp_t                     o_cfg_bresp,
  input  logic                      i_cfg_arvalid,
  output logic                      o_cfg_arready,
  input  logic [`MVM_ADDR_W-1:0]    i_cfg_araddr,
  output logic                      o_cfg_rvalid,
  input  logic                      i_cfg_rready,
  output logic [`MVM_DATA_W-1:0]    o_cfg_rdata,
  output resp_t                     o_cfg_rresp,
  // Engine side
  output logic                      o_enable,
  output shift_t                    o_shift,
  input  logic                      i_res_done,
  output logic                      o_irq_status
);

  axil_wr_state_e             wr_state_q;
  axil_rd_state_e             rd_state_q;
  logic                       wr_accept;
  logic                       rd_accept;
  resp_t                      wr_resp;
  resp_t                      rd_resp;
  logic [`MVM_DATA_W-1:0]     rd_word;
  resp_t                      bresp_q;
  resp_t                      rresp_q;
  logic [`MVM_DATA_W-1:0]     rdata_q;

  logic                       ctrl_q;
  shift_t                     shift_q;
  cnt_t                       target_q;
  cnt_t                       count_q;
  logic                       irq_q;
  cnt_t                       count_inc;
  logic                       hit_target;
  logic                       irq_clr;

  // ----------------------------------------------------------------------
  // Write channel
  // ----------------------------------------------------------------------
  assign wr_accept     = (wr_state_q == WR_IDLE) && i_cfg_awvalid && i_cfg_wvalid;
  assign o_cfg_awready = wr_accept;
  assign o_cfg_wready  = wr_accept;
  assign o_cfg_bvalid  = (wr_state_q == WR_RESP);
  assign o_cfg_bresp   = bresp_q;

  // COUNT is read only
  always_comb begin
    case (i_cfg_awaddr)
      `MVM_REG_CTRL, `MVM_REG_SHIFT, `MVM_REG_TARGET, `MVM_REG_IRQ: wr_resp = RESP_OKAY;
      default: wr_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_state_q <= WR_IDLE;
    end else begin
      case (wr_state_q)
        WR_IDLE: if (wr_accept) wr_state_q <= WR_RESP;
        WR_RESP: if (i_cfg_bready) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_accept) bresp_q <= wr_resp;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_q   <= 1'b0;
      shift_q  <= '0;
      target_q <= '0;
    end else if (wr_accept) begin
      case (i_cfg_awaddr)
        `MVM_REG_CTRL:   ctrl_q   <= i_cfg_wdata[0];
        `MVM_REG_SHIFT:  shift_q  <= i_cfg_wdata[$bits(shift_t)-1:0];
        `MVM_REG_TARGET: target_q <= i_cfg_wdata[$bits(cnt_t)-1:0];
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Result counter and interrupt
  // ----------------------------------------------------------------------
  assign count_inc  = count_q + cnt_t'(1);
  assign hit_target = i_res_done && (target_q != '0) && (count_inc == target_q);
  // W1C on bit 0
  assign irq_clr    = wr_accept && (i_cfg_awaddr == `MVM_REG_IRQ) && i_cfg_wdata[0];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count_q <= '0;
      irq_q   <= 1'b0;
    end else begin
      if (i_res_done) count_q <= count_inc;
      // A new hit wins over a clear in the same cycle
      if (hit_target) irq_q <= 1'b1;
      else if (irq_clr) irq_q <= 1'b0;
    end
  end

  assign o_enable     = ctrl_q;
  assign o_shift      = shift_q;
  assign o_irq_status = irq_q;

  // ----------------------------------------------------------------------
  // Read channel
  // ----------------------------------------------------------------------
  assign o_cfg_arready = (rd_state_q == RD_IDLE);
  assign rd_accept     = o_cfg_arready && i_cfg_arvalid;
  assign o_cfg_rvalid  = (rd_state_q == RD_DATA);
  assign o_cfg_rdata   = rdata_q;
  assign o_cfg_rresp   = rresp_q;

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (i_cfg_araddr)
      `MVM_REG_CTRL:   rd_word[0] = ctrl_q;
      `MVM_REG_SHIFT:  rd_word[$bits(shift_t)-1:0] = shift_q;
      `MVM_REG_TARGET: rd_word[$bits(cnt_t)-1:0] = target_q;
      `MVM_REG_COUNT:  rd_word[$bits(cnt_t)-1:0] = count_q;
      `MVM_REG_IRQ:    rd_word[0] = irq_q;
      default:         rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_state_q <= RD_IDLE;
    end else begin
      case (rd_state_q)
        RD_IDLE: if (rd_accept) rd_state_q <= RD_DATA;
        RD_DATA: if (i_cfg_rready) rd_state_q <= RD_IDLE;
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_accept) begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
  end

  a_bvalid_after_write: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    $rose(o_cfg_bvalid) |-> $past(wr_accept)
  );

  // Master only issues full-word writes
  a_full_word_write: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    wr_accept |-> (&i_cfg_wstrb)
  );

endmodule

// ==== mvm_dot_engine.sv ====
// Dot product engine
// Joins activation and weight beats, accumulates signed lane products
`timescale 1ns/100ps
`include "mvm_part_params.svh"

module mvm_dot_engine
  import mvm_part_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_enable,
  input  shift_t i_shift,
  // Activations
  input  logic   i_act_valid,
  output logic   o_act_ready,
  input  pword_t i_act_data,
  input  logic   i_act_last,
  // Weights
  input  logic   i_wgt_valid,
  output logic   o_wgt_ready,
  input  pword_t i_wgt_data,
  input  logic   i_wgt_last,
  // Results
  output logic   o_res_valid,
  input  logic   i_res_ready,
  output acc_t   o_res_data,
  output logic   o_res_last,
  output logic   o_res_done
);

  logic slot_free;
  logic join_fire;
  logic res_valid_q;
  acc_t res_data_q;
  acc_t acc_q;
  acc_t beat_sum;
  acc_t acc_next;

  // ----------------------------------------------------------------------
  // Stream join
  // ----------------------------------------------------------------------
  // No beats while disabled or while a result is waiting
  assign slot_free   = i_enable && !res_valid_q;
  assign o_act_ready = slot_free && i_wgt_valid;
  assign o_wgt_ready = slot_free && i_act_valid;
  assign join_fire   = slot_free && i_act_valid && i_wgt_valid;

  // ----------------------------------------------------------------------
  // Lane MAC
  // ----------------------------------------------------------------------
  always_comb begin
    beat_sum = '0;
    for (int l = 0; l < `MVM_LANES; l++) begin : g_lane
      elem_t act_e;
      elem_t wgt_e;
      act_e    = i_act_data[l*`MVM_ELEM_W +: `MVM_ELEM_W];
      wgt_e    = i_wgt_data[l*`MVM_ELEM_W +: `MVM_ELEM_W];
      // Products sign-extend to the accumulator width, sum wraps
      beat_sum = beat_sum + act_e * wgt_e;
    end
  end

  assign acc_next = acc_q + beat_sum;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      acc_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (join_fire) acc_q <= i_act_last ? '0 : acc_next;
      if (join_fire && i_act_last) res_valid_q <= 1'b1;
      else if (i_res_ready) res_valid_q <= 1'b0;
    end
  end

  // Arithmetic shift of the final sum
  always_ff @(posedge i_clk) begin
    if (join_fire && i_act_last) res_data_q <= acc_next >>> i_shift;
  end

  assign o_res_valid = res_valid_q;
  assign o_res_data  = res_data_q;
  // Every result is a one-word vector
  assign o_res_last  = 1'b1;
  assign o_res_done  = res_valid_q && i_res_ready;

  // Weight framing has to line up with the activation framing
  a_last_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    join_fire |-> (i_wgt_last == i_act_last)
  );

endmodule

// ==== mvm_part_p.sv ====
// Partition wrapper of the mvm dot product core
// Spill registers on every stream, CSRs and registered sideband outputs
`timescale 1ns/100ps
`include "mvm_part_params.svh"

module mvm_part_p
  import mvm_part_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  // Activation stream
  input  logic                     i_ifd_tvalid,
  output logic                     o_ifd_tready,
  input  pword_t                   i_ifd_tdata,
  input  logic                     i_ifd_tlast,
  // Weight stream
  input  logic                     i_ifdw_tvalid,
  output logic                     o_ifdw_tready,
  input  pword_t                   i_ifdw_tdata,
  input  logic                     i_ifdw_tlast,
  // Result stream
  output logic                     o_odr_tvalid,
  input  logic                     i_odr_tready,
  output pword_t                   o_odr_tdata,
  output logic                     o_odr_tlast,
  // AXI4-Lite config
  input  logic                     i_cfg_awvalid,
  output logic                     o_cfg_awready,
  input  logic [`MVM_ADDR_W-1:0]   i_cfg_awaddr,
  input  logic                     i_cfg_wvalid,
  output logic                     o_cfg_wready,
  input  logic [`MVM_DATA_W-1:0]   i_cfg_wdata,
  input  logic [`MVM_DATA_W/8-1:0] i_cfg_wstrb,
  output logic                     o_cfg_bvalid,
  input  logic                     i_cfg_bready,
  output resp_t                    o_cfg_bresp,
  input  logic                     i_cfg_arvalid,
  output logic                     o_cfg_arready,
  input  logic [`MVM_ADDR_W-1:0]   i_cfg_araddr,
  output logic                     o_cfg_rvalid,
  input  logic                     i_cfg_rready,
  output logic [`MVM_DATA_W-1:0]   o_cfg_rdata,
  output resp_t                    o_cfg_rresp,
  // Sideband
  output logic                     o_irq,
  output cnt_t                     o_obs_count
);

  localparam int StreamW = `MVM_PWORD_W + 1;

  logic   act_valid, act_ready, act_last;
  pword_t act_data;
  logic   wgt_valid, wgt_ready, wgt_last;
  pword_t wgt_data;
  logic   res_valid, res_ready, res_last, res_done;
  acc_t   res_data;
  logic   enable;
  shift_t shift;
  logic   irq_status;
  cnt_t   obs_count_next;

  // ----------------------------------------------------------------------
  // Stream cuts
  // ----------------------------------------------------------------------
  mvm_spill_reg #(.DataWidth(StreamW)) u_ifd_spill_reg (
    .i_clk, .i_rst_n,
    .i_valid(i_ifd_tvalid), .o_ready(o_ifd_tready), .i_data({i_ifd_tlast, i_ifd_tdata}),
    .o_valid(act_valid), .i_ready(act_ready), .o_data({act_last, act_data})
  );

  mvm_spill_reg #(.DataWidth(StreamW)) u_ifdw_spill_reg (
    .i_clk, .i_rst_n,
    .i_valid(i_ifdw_tvalid), .o_ready(o_ifdw_tready), .i_data({i_ifdw_tlast, i_ifdw_tdata}),
    .o_valid(wgt_valid), .i_ready(wgt_ready), .o_data({wgt_last, wgt_data})
  );

  mvm_spill_reg #(.DataWidth(StreamW)) u_odr_spill_reg (
    .i_clk, .i_rst_n,
    .i_valid(res_valid), .o_ready(res_ready), .i_data({res_last, res_data}),
    .o_valid(o_odr_tvalid), .i_ready(i_odr_tready), .o_data({o_odr_tlast, o_odr_tdata})
  );

  // ----------------------------------------------------------------------
  // Control and datapath
  // ----------------------------------------------------------------------
  mvm_cfg_ctrl u_mvm_cfg_ctrl (
    .i_clk, .i_rst_n,
    .i_cfg_awvalid, .o_cfg_awready, .i_cfg_awaddr,
    .i_cfg_wvalid, .o_cfg_wready, .i_cfg_wdata, .i_cfg_wstrb,
    .o_cfg_bvalid, .i_cfg_bready, .o_cfg_bresp,
    .i_cfg_arvalid, .o_cfg_arready, .i_cfg_araddr,
    .o_cfg_rvalid, .i_cfg_rready, .o_cfg_rdata, .o_cfg_rresp,
    .o_enable(enable), .o_shift(shift), .i_res_done(res_done), .o_irq_status(irq_status)
  );

  mvm_dot_engine u_mvm_dot_engine (
    .i_clk, .i_rst_n,
    .i_enable(enable), .i_shift(shift),
    .i_act_valid(act_valid), .o_act_ready(act_ready),
    .i_act_data(act_data), .i_act_last(act_last),
    .i_wgt_valid(wgt_valid), .o_wgt_ready(wgt_ready),
    .i_wgt_data(wgt_data), .i_wgt_last(wgt_last),
    .o_res_valid(res_valid), .i_res_ready(res_ready),
    .o_res_data(res_data), .o_res_last(res_last), .o_res_done(res_done)
  );

  // Results handed off at the odr port
  assign obs_count_next = o_obs_count + cnt_t'(o_odr_tvalid && i_odr_tready);

  // Boundary flops only toggle when the source moves
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_irq       <= 1'b0;
      o_obs_count <= '0;
    end else begin
      if (o_irq ^ irq_status) o_irq <= irq_status;
      if (o_obs_count != obs_count_next) o_obs_count <= obs_count_next;
    end
  end

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset source
// 100 ns clock, active-low reset held for the first 4 cycles
`timescale 1ns/100ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam time HalfPeriod = 50;

  initial begin
    o_clk = 1'b0;
    forever #(HalfPeriod) o_clk = ~o_clk;
  end

  // Release on a falling edge, after 4 rising edges in reset
  initial begin
    o_rst_n = 1'b0;
    repeat (4) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// ==== tb_mvm_part.sv ====
// Testbench of the mvm_part partition
// Random vectors on both input streams, CSR accesses and a result scoreboard
`timescale 1ns/100ps
`include "mvm_part_params.svh"

module tb_mvm_part
  import mvm_part_pkg::*;
();

  // About 120 vectors of up to 8 beats, partly at reduced throughput,
  // plus CSR traffic stay far below this
  localparam int TimeoutCycles = 20000;

  logic clk;
  logic rst_n;
  logic i_ifd_tvalid, o_ifd_tready, i_ifd_tlast;
  pword_t i_ifd_tdata;
  logic i_ifdw_tvalid, o_ifdw_tready, i_ifdw_tlast;
  pword_t i_ifdw_tdata;
  logic o_odr_tvalid, i_odr_tready, o_odr_tlast;
  pword_t o_odr_tdata;
  logic i_cfg_awvalid, o_cfg_awready, i_cfg_wvalid, o_cfg_wready;
  logic [`MVM_ADDR_W-1:0] i_cfg_awaddr, i_cfg_araddr;
  logic [`MVM_DATA_W-1:0] i_cfg_wdata, o_cfg_rdata;
  logic [`MVM_DATA_W/8-1:0] i_cfg_wstrb;
  logic o_cfg_bvalid, i_cfg_bready, i_cfg_arvalid, o_cfg_arready;
  logic o_cfg_rvalid, i_cfg_rready;
  resp_t o_cfg_bresp, o_cfg_rresp;
  logic o_irq;
  cnt_t o_obs_count;

  // Pending beats as {last, data}, and expected results
  logic [`MVM_PWORD_W:0] act_q[$];
  logic [`MVM_PWORD_W:0] wgt_q[$];
  acc_t exp_q[$];
  pword_t vec_act [8];
  pword_t vec_wgt [8];
  logic act_taken;
  logic wgt_taken;
  int gap_pct;
  int ready_pct;
  int rx_count;
  int irq_goal;
  logic irq_watch;
  int cycle_cnt;
  int unsigned seed_dummy;

  tb_clk_gen u_tb_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

  mvm_part_p i_mvm_part_p (.i_clk(clk), .i_rst_n(rst_n), .*);

  // ----------------------------------------------------------------------
  // Reference model and checks
  // ----------------------------------------------------------------------
  function automatic acc_t ref_dot(input int beats, input shift_t shamt);
    acc_t  sum;
    elem_t a_e;
    elem_t w_e;
    sum = '0;
    for (int b = 0; b < beats; b++) begin
      for (int l = 0; l < `MVM_LANES; l++) begin
        a_e = vec_act[b][l*`MVM_ELEM_W +: `MVM_ELEM_W];
        w_e = vec_wgt[b][l*`MVM_ELEM_W +: `MVM_ELEM_W];
        sum = sum + acc_t'(int'(a_e) * int'(w_e));
      end
    end
    return sum >>> shamt;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("[ERROR] %0t %s: expected 0x%08h, got 0x%08h", $time, sig, exp, got);
      fail_run("Value mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // AXI4-Lite master
  // ----------------------------------------------------------------------
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output resp_t resp);
    @(negedge clk);
    i_cfg_awvalid = 1'b1;
    i_cfg_awaddr  = addr;
    i_cfg_wvalid  = 1'b1;
    i_cfg_wdata   = data;
    @(posedge clk);
    while (!(o_cfg_awready && o_cfg_wready)) @(posedge clk);
    @(negedge clk);
    i_cfg_awvalid = 1'b0;
    i_cfg_wvalid  = 1'b0;
    i_cfg_bready  = 1'b1;
    @(posedge clk);
    while (!o_cfg_bvalid) @(posedge clk);
    resp = o_cfg_bresp;
    @(negedge clk);
    i_cfg_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output resp_t resp);
    @(negedge clk);
    i_cfg_arvalid = 1'b1;
    i_cfg_araddr  = addr;
    @(posedge clk);
    while (!o_cfg_arready) @(posedge clk);
    @(negedge clk);
    i_cfg_arvalid = 1'b0;
    i_cfg_rready  = 1'b1;
    @(posedge clk);
    while (!o_cfg_rvalid) @(posedge clk);
    data = o_cfg_rdata;
    resp = o_cfg_rresp;
    @(negedge clk);
    i_cfg_rready = 1'b0;
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input resp_t exp_resp);
    resp_t resp;
    axil_write(addr, data, resp);
    check_value($sformatf("o_cfg_bresp @0x%02h", addr), 32'(resp), 32'(exp_resp));
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                             input resp_t exp_resp);
    logic [31:0] data;
    resp_t resp;
    axil_read(addr, data, resp);
    check_value($sformatf("o_cfg_rresp @0x%02h", addr), 32'(resp), 32'(exp_resp));
    check_value($sformatf("o_cfg_rdata @0x%02h", addr), data, exp_data);
  endtask

  // ----------------------------------------------------------------------
  // Stream traffic
  // ----------------------------------------------------------------------
  task automatic send_vector(input shift_t shamt);
    int beats;
    logic last;
    beats = $urandom_range(8, 1);
    for (int b = 0; b < beats; b++) begin
      last = (b == beats - 1);
      vec_act[b] = $urandom();
      vec_wgt[b] = $urandom();
      act_q.push_back({last, vec_act[b]});
      wgt_q.push_back({last, vec_wgt[b]});
    end
    exp_q.push_back(ref_dot(beats, shamt));
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || act_q.size() != 0 || wgt_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  always @(posedge clk) begin
    act_taken = i_ifd_tvalid && o_ifd_tready;
    wgt_taken = i_ifdw_tvalid && o_ifdw_tready;
  end

  // Activation sender, holds a beat until it is taken
  always @(negedge clk) begin : drive_act
    logic [`MVM_PWORD_W:0] beat;
    if (act_taken) beat = act_q.pop_front();
    if (!i_ifd_tvalid || act_taken) begin
      if (act_q.size() > 0 && $urandom_range(99) >= gap_pct) begin
        {i_ifd_tlast, i_ifd_tdata} = act_q[0];
        i_ifd_tvalid = 1'b1;
      end else begin
        i_ifd_tvalid = 1'b0;
      end
    end
  end

  // Weight sender
  always @(negedge clk) begin : drive_wgt
    logic [`MVM_PWORD_W:0] beat;
    if (wgt_taken) beat = wgt_q.pop_front();
    if (!i_ifdw_tvalid || wgt_taken) begin
      if (wgt_q.size() > 0 && $urandom_range(99) >= gap_pct) begin
        {i_ifdw_tlast, i_ifdw_tdata} = wgt_q[0];
        i_ifdw_tvalid = 1'b1;
      end else begin
        i_ifdw_tvalid = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    i_odr_tready = ($urandom_range(99) < ready_pct);
  end

  // Scoreboard on every odr transfer
  always @(posedge clk) begin : compare_results
    acc_t exp_val;
    if (rst_n && o_odr_tvalid && i_odr_tready) begin
      assert (exp_q.size() > 0)
      else fail_run("Result received while no vector was outstanding");
      exp_val = exp_q.pop_front();
      check_value("o_odr_tdata", o_odr_tdata, exp_val);
      check_value("o_odr_tlast", 32'(o_odr_tlast), 32'd1);
      if (irq_watch && rx_count + 1 < irq_goal) check_value("o_irq", 32'(o_irq), 32'd0);
      rx_count++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) fail_run("Timeout: the run did not finish in time");
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int wait_cnt;
    seed_dummy    = $urandom(32'h9aa850bc);
    i_ifd_tvalid  = 1'b0;
    i_ifd_tdata   = '0;
    i_ifd_tlast   = 1'b0;
    i_ifdw_tvalid = 1'b0;
    i_ifdw_tdata  = '0;
    i_ifdw_tlast  = 1'b0;
    i_odr_tready  = 1'b0;
    i_cfg_awvalid = 1'b0;
    i_cfg_awaddr  = '0;
    i_cfg_wvalid  = 1'b0;
    i_cfg_wdata   = '0;
    i_cfg_wstrb   = '1;
    i_cfg_bready  = 1'b0;
    i_cfg_arvalid = 1'b0;
    i_cfg_araddr  = '0;
    i_cfg_rready  = 1'b0;
    act_taken     = 1'b0;
    wgt_taken     = 1'b0;
    gap_pct       = 0;
    ready_pct     = 100;
    rx_count      = 0;
    irq_goal      = 0;
    irq_watch     = 1'b0;
    cycle_cnt     = 0;
    @(posedge rst_n);

    // Reset values and read-back
    read_expect(`MVM_REG_CTRL, 32'h0, RESP_OKAY);
    read_expect(`MVM_REG_SHIFT, 32'h0, RESP_OKAY);
    read_expect(`MVM_REG_TARGET, 32'h0, RESP_OKAY);
    read_expect(`MVM_REG_COUNT, 32'h0, RESP_OKAY);
    read_expect(`MVM_REG_IRQ, 32'h0, RESP_OKAY);
    check_value("o_obs_count", 32'(o_obs_count), 32'd0);
    write_expect(`MVM_REG_CTRL, 32'h1, RESP_OKAY);
    read_expect(`MVM_REG_CTRL, 32'h1, RESP_OKAY);
    write_expect(`MVM_REG_SHIFT, 32'h13, RESP_OKAY);
    read_expect(`MVM_REG_SHIFT, 32'h13, RESP_OKAY);
    write_expect(`MVM_REG_TARGET, 32'ha5c3, RESP_OKAY);
    read_expect(`MVM_REG_TARGET, 32'ha5c3, RESP_OKAY);
    write_expect(`MVM_REG_TARGET, 32'h0, RESP_OKAY);
    write_expect(`MVM_REG_CTRL, 32'h0, RESP_OKAY);

    // Error responses
    read_expect(8'h14, 32'h0, RESP_SLVERR);
    write_expect(8'h14, 32'hdead_beef, RESP_SLVERR);
    write_expect(`MVM_REG_COUNT, 32'h1234, RESP_SLVERR);
    read_expect(`MVM_REG_COUNT, 32'h0, RESP_OKAY);

    // Plain flow, no shift
    write_expect(`MVM_REG_SHIFT, 32'h0, RESP_OKAY);
    write_expect(`MVM_REG_CTRL, 32'h1, RESP_OKAY);
    repeat (40) send_vector(5'd0);
    wait_drain();
    check_value("o_obs_count", 32'(o_obs_count), 32'(rx_count));

    // Gaps on the inputs and back-pressure on the output
    gap_pct   = 30;
    ready_pct = 60;
    repeat (40) send_vector(5'd0);
    wait_drain();
    check_value("o_obs_count", 32'(o_obs_count), 32'(rx_count));

    // Nonzero shift
    write_expect(`MVM_REG_SHIFT, 32'd5, RESP_OKAY);
    repeat (30) send_vector(5'd5);
    wait_drain();
    read_expect(`MVM_REG_COUNT, 32'(rx_count), RESP_OKAY);
    check_value("o_obs_count", 32'(o_obs_count), 32'(rx_count));

    // Interrupt at a target count, then clear
    gap_pct   = 0;
    ready_pct = 100;
    write_expect(`MVM_REG_IRQ, 32'h1, RESP_OKAY);
    irq_goal  = rx_count + 5;
    write_expect(`MVM_REG_TARGET, 32'(irq_goal), RESP_OKAY);
    irq_watch = 1'b1;
    repeat (5) send_vector(5'd5);
    wait_drain();
    wait_cnt = 0;
    while (!o_irq && wait_cnt < 4) begin
      @(posedge clk);
      wait_cnt++;
    end
    assert (o_irq)
    else fail_run("o_irq stayed low after the target result was received");
    read_expect(`MVM_REG_IRQ, 32'h1, RESP_OKAY);
    write_expect(`MVM_REG_IRQ, 32'h1, RESP_OKAY);
    repeat (2) @(posedge clk);
    check_value("o_irq", 32'(o_irq), 32'd0);
    repeat (4) send_vector(5'd5);
    wait_drain();
    check_value("o_irq", 32'(o_irq), 32'd0);
    read_expect(`MVM_REG_IRQ, 32'h0, RESP_OKAY);
    read_expect(`MVM_REG_COUNT, 32'(rx_count), RESP_OKAY);
    check_value("o_obs_count", 32'(o_obs_count), 32'(rx_count));

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== mvm_part.f ====
+incdir+.
mvm_part_pkg.sv
mvm_spill_reg.sv
mvm_cfg_ctrl.sv
mvm_dot_engine.sv
mvm_part_p.sv
tb_clk_gen.sv
tb_mvm_part.sv

// ==== Bender.yml ====
package:
  name: mvm_part

export_include_dirs:
  - .

sources:
  - mvm_part_pkg.sv
  - mvm_spill_reg.sv
  - mvm_cfg_ctrl.sv
  - mvm_dot_engine.sv
  - mvm_part_p.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_mvm_part.sv
